//--- hdl/coreBusyCtl.sv
// Core busy and NXM control
`timescale 1ns/1ps
`include "mbox_defs.svh"

module coreBusyCtl import mboxPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    memStart,
  input  logic                    memWrite,
  input  logic                    chanCyc,
  input  logic                    ackn,
  input  logic                    nxmClear,
  input  logic [`MBOX_ADDR_W-1:0] memAddr,
  memCycleIf.ctl                  cyc
);

  localparam int CntW        = $clog2(`MBOX_NXM_TIMEOUT + `MBOX_NXM_SEQ + 1);
  localparam int TimeoutLast = `MBOX_NXM_TIMEOUT - 1;
  localparam int SeqLast     = `MBOX_NXM_TIMEOUT + `MBOX_NXM_SEQ - 1;

  logic            busyAny;
  logic            accept;
  logic            ackPend;
  logic            timeout;
  logic            seqDone;
  logic            cycEnd;
  logic [CntW-1:0] cycCnt;

  always_comb begin
    // Start pulse counts as busy so a second strobe is dropped
    busyAny = cyc.coreBusy | cyc.memStart;
    accept  = memStart & ~busyAny;

    // No timeout when memory answered at this edge or the one before
    timeout = busyAny & ~cyc.nxmFlag & ~ackn & ~ackPend &
              (cycCnt == CntW'(TimeoutLast));
    seqDone = cyc.nxmFlag & (cycCnt == CntW'(SeqLast));
    cycEnd  = ackPend | seqDone;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc.memStart <= 1'b0;
      cyc.coreBusy <= 1'b0;
      cyc.chanRef  <= 1'b0;
      cyc.nxmFlag  <= 1'b0;
      cyc.nxmErr   <= 1'b0;
      ackPend      <= 1'b0;
      cycCnt       <= '0;
    end else begin
      cyc.memStart <= accept;

      // Acknowledge is ignored once the NXM sequence runs
      ackPend <= ackn & busyAny & ~cyc.nxmFlag;

      if (cycEnd) begin
        cyc.coreBusy <= 1'b0;
      end else if (cyc.memStart) begin
        cyc.coreBusy <= 1'b1;
      end

      if (accept) begin
        cyc.chanRef <= chanCyc;
      end else if (cycEnd) begin
        cyc.chanRef <= 1'b0;
      end

      // One counter covers both the timeout and the sequence steps
      if (accept) begin
        cycCnt <= '0;
      end else if (busyAny) begin
        cycCnt <= cycCnt + 1'b1;
      end

      if (seqDone) begin
        cyc.nxmFlag <= 1'b0;
      end else if (timeout) begin
        cyc.nxmFlag <= 1'b1;
      end

      // Set wins over a clear in the same cycle
      cyc.nxmErr <= seqDone | (cyc.nxmErr & ~nxmClear);
    end
  end

  // Reference attributes, held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      cyc.cycleRec <= '{addr: memAddr, write: memWrite, chanRef: chanCyc};
    end
  end

endmodule

//--- hdl/diagReadMux.sv
// Error hold, ERA and diagnostic read
`timescale 1ns/1ps
`include "mbox_defs.svh"

module diagReadMux import mboxPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  memCycleIf.diag                  cyc,
  input  logic [`MBOX_NUM_ERR-1:0] errFlags,
  input  logic                     diagRead,
  input  diagSel_e                 diagSel,
  output logic [`MBOX_DIAG_W-1:0]  diagData
);

  logic                    errHold;
  eraRec_t                 era;
  logic [`MBOX_DIAG_W-1:0] statusWord;
  logic [`MBOX_DIAG_W-1:0] addrWord;
  logic [`MBOX_DIAG_W-1:0] attrWord;
  logic [`MBOX_DIAG_W-1:0] selWord;

  assign errHold = (|errFlags) | cyc.nxmErr;

  // ERA freezes on the first held error
  always_ff @(posedge clk) begin
    if (rst) begin
      era <= '0;
    end else if (cyc.memStart && !errHold) begin
      era <= cyc.cycleRec;
    end
  end

  always_comb begin
    statusWord                = '0;
    statusWord[0]             = cyc.coreBusy;
    statusWord[1]             = cyc.nxmFlag;
    statusWord[2]             = cyc.nxmErr;
    statusWord[3+ERR_SBUS]    = errFlags[ERR_SBUS];
    statusWord[3+ERR_MB_PAR]  = errFlags[ERR_MB_PAR];
    statusWord[3+ERR_ADR_PAR] = errFlags[ERR_ADR_PAR];

    addrWord                   = '0;
    addrWord[`MBOX_ADDR_W-1:0] = era.addr;

    attrWord    = '0;
    attrWord[0] = era.write;
    attrWord[1] = era.chanRef;
  end

  always_comb begin
    case (diagSel)
      DIAG_STATUS:   selWord = statusWord;
      DIAG_ERA_ADDR: selWord = addrWord;
      DIAG_ERA_ATTR: selWord = attrWord;
      default:       selWord = '0;
    endcase
    // Bus idles at zero
    diagData = diagRead ? selWord : '0;
  end

endmodule

//--- hdl/errorFlag.sv
// Sticky error flag cell
`timescale 1ns/1ps

module errorFlag (
  input  logic    clk,
  input  logic    rst,
  input  logic    errEvent,
  input  logic    errClear,
  memCycleIf.flag cyc,
  output logic    flag,
  output logic    chanErr
);

  logic capture;
  logic setPend;
  logic chanQ;
  logic flagQ;

  // Events only count during a memory cycle
  assign capture = errEvent & cyc.coreBusy;

  always_ff @(posedge clk) begin
    if (rst) begin
      setPend <= 1'b0;
      chanQ   <= 1'b0;
      flag    <= 1'b0;
      flagQ   <= 1'b0;
    end else begin
      setPend <= capture;
      // Keep the qualifier of the event that raises the flag
      if (capture & ~setPend) begin
        chanQ <= cyc.chanRef;
      end
      flag  <= setPend | (flag & ~errClear);
      flagQ <= flag;
    end
  end

  // First-error pulse, channel references only
  assign chanErr = flag & ~flagQ & chanQ;

endmodule

//--- hdl/mboxErrTop.sv
// Memory box error and busy top
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mboxErrTop import mboxPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     memStart,
  input  logic [`MBOX_ADDR_W-1:0]  memAddr,
  input  logic                     memWrite,
  input  logic                     chanCyc,
  input  logic                     ackn,
  input  logic                     nxmClear,
  input  logic [`MBOX_NUM_ERR-1:0] errEvent,
  input  logic [`MBOX_NUM_ERR-1:0] errClear,
  input  logic                     diagRead,
  input  logic [1:0]               diagSel,
  output logic                     coreBusy,
  output logic                     nxmErr,
  output logic [`MBOX_NUM_ERR-1:0] errFlags,
  output logic [`MBOX_NUM_ERR-1:0] chanErr,
  output logic [`MBOX_DIAG_W-1:0]  diagData
);

  memCycleIf cyc ();

  coreBusyCtl uCtl (
    .clk      (clk),
    .rst      (rst),
    .memStart (memStart),
    .memWrite (memWrite),
    .chanCyc  (chanCyc),
    .ackn     (ackn),
    .nxmClear (nxmClear),
    .memAddr  (memAddr),
    .cyc      (cyc.ctl)
  );

  // Bus error, MB parity and address parity cells
  for (genvar i = 0; i < `MBOX_NUM_ERR; i++) begin : gFlag
    errorFlag uFlag (
      .clk      (clk),
      .rst      (rst),
      .errEvent (errEvent[i]),
      .errClear (errClear[i]),
      .cyc      (cyc.flag),
      .flag     (errFlags[i]),
      .chanErr  (chanErr[i])
    );
  end

  diagReadMux uDiag (
    .clk      (clk),
    .rst      (rst),
    .cyc      (cyc.diag),
    .errFlags (errFlags),
    .diagRead (diagRead),
    .diagSel  (diagSel_e'(diagSel)),
    .diagData (diagData)
  );

  assign coreBusy = cyc.coreBusy;
  assign nxmErr   = cyc.nxmErr;

endmodule

//--- hdl/mboxPkg.sv
// Memory box error types
`include "mbox_defs.svh"

package mboxPkg;

  // Reference attributes captured at cycle start
  typedef struct packed {
    logic [`MBOX_ADDR_W-1:0] addr;
    logic                    write;
    logic                    chanRef;
  } eraRec_t;

  typedef enum logic [1:0] {
    DIAG_STATUS   = 2'd0,
    DIAG_ERA_ADDR = 2'd1,
    DIAG_ERA_ATTR = 2'd2
  } diagSel_e;

  typedef enum logic [1:0] {
    ERR_SBUS    = 2'd0,
    ERR_MB_PAR  = 2'd1,
    ERR_ADR_PAR = 2'd2
  } errIdx_e;

endpackage

//--- hdl/mbox_defs.svh
// Memory box error slice constants
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// Physical address width
`define MBOX_ADDR_W 22

// Sticky error flag cells
`define MBOX_NUM_ERR 3

// Busy cycles without acknowledge before NXM
`define MBOX_NXM_TIMEOUT 16

// Steps of the NXM sequence after timeout
`define MBOX_NXM_SEQ 4

// Diagnostic bus width
`define MBOX_DIAG_W 24

`endif

//--- hdl/memCycleIf.sv
// Memory cycle status bundle
`timescale 1ns/1ps

interface memCycleIf import mboxPkg::*; ();

  // One-cycle start pulse, cycleRec valid with it
  logic    memStart;
  eraRec_t cycleRec;

  logic    coreBusy;
  logic    chanRef;

  // NXM sequence in progress and sticky NXM error
  logic    nxmFlag;
  logic    nxmErr;

  modport ctl (
    output memStart, cycleRec, coreBusy, chanRef, nxmFlag, nxmErr
  );

  modport flag (
    input coreBusy, chanRef
  );

  modport diag (
    input memStart, cycleRec, coreBusy, nxmFlag, nxmErr
  );

endinterface

//--- project.f
+incdir+hdl
hdl/mboxPkg.sv
hdl/memCycleIf.sv
hdl/coreBusyCtl.sv
hdl/errorFlag.sv
hdl/diagReadMux.sv
hdl/mboxErrTop.sv
verification/mboxErr_asserts.sv
verification/mboxErrTb.sv

//--- verification/mboxErrTb.sv
// Memory box error slice testbench
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mboxErrTb import mboxPkg::*; ();

  localparam int NumErr   = `MBOX_NUM_ERR;
  localparam int NxmEdges = `MBOX_NXM_TIMEOUT + `MBOX_NXM_SEQ;
  // Worst-case cycles: reset, five tests, margin
  localparam int WatchCycles = 10 + 12 + 15 + (NxmEdges + 30) + 35 + 40 + 200;

  logic clk, rst, memStart, memWrite, chanCyc, ackn, nxmClear, diagRead;
  logic [`MBOX_ADDR_W-1:0] memAddr;
  logic [NumErr-1:0] errEvent, errClear, errFlags, chanErr;
  logic [1:0] diagSel;
  logic coreBusy, nxmErr;
  logic [`MBOX_DIAG_W-1:0] diagData;

  int errCount = 0;
  int failTests = 0;
  int numTests = 0;
  string tName;

  mboxErrTop dut (.*);

  bind mboxErrTop mboxErrAsserts uAsserts (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WatchCycles) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

  task automatic checkVal(input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else begin
      $display("ERROR %s expected=%h actual=%h", tName, exp, act);
      errCount++;
    end
  endtask

  task automatic noteFail(input string msg);
    $display("%s: %s", tName, msg);
    errCount++;
  endtask

  task automatic finishTest(input int errAtStart);
    numTests++;
    if (errCount == errAtStart) begin
      $display("PASS %s", tName);
    end else begin
      failTests++;
      $display("FAIL %s (%0d errors)", tName, errCount - errAtStart);
    end
  endtask

  // Returns after the edge that sampled the start strobe
  task automatic startCycle(input logic [`MBOX_ADDR_W-1:0] addr, input logic wr,
                            input logic chan);
    @(negedge clk);
    memStart = 1'b1;
    memAddr  = addr;
    memWrite = wr;
    chanCyc  = chan;
    @(negedge clk);
    memStart = 1'b0;
  endtask

  task automatic runCycle(input logic [`MBOX_ADDR_W-1:0] addr, input logic wr,
                          input logic chan, input logic [NumErr-1:0] ev);
    startCycle(addr, wr, chan);
    @(negedge clk);
    errEvent = ev;
    @(negedge clk);
    errEvent = '0;
    ackn     = 1'b1;
    @(negedge clk);
    ackn = 1'b0;
    @(negedge clk);
  endtask

  task automatic readDiag(input logic [1:0] sel, output logic [`MBOX_DIAG_W-1:0] val);
    @(negedge clk);
    diagRead = 1'b1;
    diagSel  = sel;
    #1;
    val = diagData;
    @(negedge clk);
    diagRead = 1'b0;
  endtask

  task automatic testReset();
    int e0;
    logic [`MBOX_DIAG_W-1:0] val;
    e0 = errCount;
    tName = "reset";
    @(negedge clk);
    checkVal(0, coreBusy);
    checkVal(0, nxmErr);
    checkVal(0, errFlags);
    checkVal(0, chanErr);
    for (int s = 0; s < 4; s++) begin
      readDiag(s, val);
      checkVal(0, val);
      diagSel = s;
      #1;
      checkVal(0, diagData);
    end
    finishTest(e0);
  endtask

  task automatic testAckRead();
    int e0;
    logic [`MBOX_ADDR_W-1:0] addr;
    logic [`MBOX_DIAG_W-1:0] val;
    e0 = errCount;
    tName = "ack_read";
    addr = $urandom;
    startCycle(addr, 1'b0, 1'b0);
    checkVal(0, coreBusy);
    @(negedge clk);
    checkVal(1, coreBusy);
    // Start while busy must be dropped
    memStart = 1'b1;
    memAddr  = ~addr;
    @(negedge clk);
    memStart = 1'b0;
    ackn     = 1'b1;
    @(negedge clk);
    ackn = 1'b0;
    checkVal(1, coreBusy);
    @(negedge clk);
    checkVal(0, coreBusy);
    checkVal(0, nxmErr);
    @(negedge clk);
    checkVal(0, coreBusy);
    readDiag(DIAG_ERA_ADDR, val);
    checkVal(addr, val);
    finishTest(e0);
  endtask

  task automatic testNxm();
    int e0;
    int edges;
    logic [`MBOX_DIAG_W-1:0] val;
    e0 = errCount;
    tName = "nxm_timeout";
    startCycle($urandom, 1'b0, 1'b0);
    edges = 0;
    do begin
      @(negedge clk);
      edges++;
    end while (coreBusy !== 1'b0 && edges < NxmEdges + 20);
    assert (coreBusy === 1'b0)
    else begin
      noteFail("coreBusy never dropped after the NXM timeout");
    end
    checkVal(NxmEdges, edges);
    checkVal(1, nxmErr);
    readDiag(DIAG_STATUS, val);
    checkVal(32'h4, val);
    nxmClear = 1'b1;
    @(negedge clk);
    nxmClear = 1'b0;
    checkVal(0, nxmErr);
    finishTest(e0);
  endtask

  task automatic testFlags();
    int e0;
    int idx;
    logic [NumErr-1:0] mask;
    e0 = errCount;
    tName = "error_flags";
    idx  = $urandom % NumErr;
    mask = 1 << idx;
    // Event while idle is ignored
    @(negedge clk);
    errEvent = mask;
    @(negedge clk);
    errEvent = '0;
    repeat (3) @(negedge clk);
    checkVal(0, errFlags);
    for (int chan = 0; chan < 2; chan++) begin
      startCycle($urandom, 1'b0, chan[0]);
      @(negedge clk);
      errEvent = mask;
      @(negedge clk);
      errEvent = '0;
      ackn     = 1'b1;
      @(negedge clk);
      ackn = 1'b0;
      checkVal(mask, errFlags);
      checkVal(chan ? mask : 0, chanErr);
      @(negedge clk);
      checkVal(0, chanErr);
      errClear = mask;
      @(negedge clk);
      errClear = '0;
      checkVal(0, errFlags);
    end
    finishTest(e0);
  endtask

  task automatic testEra();
    int e0;
    int idx;
    logic [`MBOX_ADDR_W-1:0] addrA, addrB, addrC;
    logic [`MBOX_DIAG_W-1:0] val;
    e0 = errCount;
    tName = "era_freeze";
    idx   = $urandom % NumErr;
    addrA = $urandom;
    addrB = addrA ^ (($urandom % 1000) + 1);
    addrC = $urandom;
    runCycle(addrA, 1'b1, 1'b1, 1 << idx);
    readDiag(DIAG_ERA_ADDR, val);
    checkVal(addrA, val);
    readDiag(DIAG_ERA_ATTR, val);
    checkVal(3, val);
    runCycle(addrB, 1'b0, 1'b0, '0);
    readDiag(DIAG_ERA_ADDR, val);
    checkVal(addrA, val);
    readDiag(DIAG_ERA_ATTR, val);
    checkVal(3, val);
    errClear = '1;
    @(negedge clk);
    errClear = '0;
    runCycle(addrC, 1'b0, 1'b0, '0);
    readDiag(DIAG_ERA_ADDR, val);
    checkVal(addrC, val);
    readDiag(DIAG_ERA_ATTR, val);
    checkVal(0, val);
    finishTest(e0);
  endtask

  initial begin
    int seedVal;
    seedVal  = $urandom(32'hea44ef73);
    rst      = 1'b1;
    memStart = 1'b0;
    memAddr  = '0;
    memWrite = 1'b0;
    chanCyc  = 1'b0;
    ackn     = 1'b0;
    nxmClear = 1'b0;
    errEvent = '0;
    errClear = '0;
    diagRead = 1'b0;
    diagSel  = 2'd0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testReset();
    testAckRead();
    testNxm();
    testFlags();
    testEra();
    if (dut.uAsserts.failCount != 0) begin
      $display("Bound assertions failed %0d times", dut.uAsserts.failCount);
      errCount += dut.uAsserts.failCount;
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", numTests, failTests, errCount);
    if (errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verification/mboxErr_asserts.sv
// Memory box busy and flag checks
`timescale 1ns/1ps
`include "mbox_defs.svh"

module mboxErrAsserts (
  input logic                     clk,
  input logic                     rst,
  input logic                     memStart,
  input logic                     coreBusy,
  input logic [`MBOX_NUM_ERR-1:0] errEvent,
  input logic [`MBOX_NUM_ERR-1:0] errFlags,
  input logic [`MBOX_NUM_ERR-1:0] chanErr
);

  int failCount = 0;

  // Start strobe two samples back, one edge for the pulse and one for busy
  busyNeedsStart: assert property (@(posedge clk) disable iff (rst)
    $rose(coreBusy) |-> $past(memStart, 2))
    else begin
      $error("coreBusy rose without a memStart");
      failCount++;
    end

  for (genvar i = 0; i < `MBOX_NUM_ERR; i++) begin : gChk
    flagNeedsBusy: assert property (@(posedge clk) disable iff (rst)
      $rose(errFlags[i]) |-> $past(errEvent[i] & coreBusy, 2))
      else begin
        $error("error flag %0d set without an event during busy", i);
        failCount++;
      end

    chanErrOneCycle: assert property (@(posedge clk) disable iff (rst)
      chanErr[i] |=> !chanErr[i])
      else begin
        $error("chanErr %0d lasted more than one cycle", i);
        failCount++;
      end
  end

endmodule
